/* bench/agen_tb.sv */
// ================================================
// Table-driven testbench for the address generator top
// Each row issues one cycle, requests are checked three cycles later
// ================================================
`timescale 1ns/1ps

module agen_tb import agen_pkg::*; ();

	localparam logic [1:0] wantDrop = 2'd0;
	localparam logic [1:0] wantRob = 2'd1;
	localparam logic [1:0] wantBeb = 2'd2;
	localparam int nRows = 21;
	localparam int cycleLimit = nRows + 20;

	// One stimulus row with store, size, exc and low address bits shared by both sources
	typedef struct packed {
		logic rob, beb, idle;
		logic [2:0] neg;
		logic st;
		accSize_t sz;
		logic exc;
		logic [2:0] low;
		logic [1:0] want;
	} tableRow_t;

	// A request as the rules predict it, with the cycle it must appear in
	typedef struct {
		robId_t id;
		address_t addr;
		value_t data;
		logic st, exc;
		accSize_t sz;
		int due;
	} expReq_t;

	// rob, beb, idle, neg(CBA), store, size, exc, low addr bits, expected source
	tableRow_t rows [nRows] = '{
		'{1, 0, 1, 3'd0, 0, 2'd2, 0, 3'd0, wantRob},
		'{1, 0, 1, 3'd1, 1, 2'd2, 0, 3'd4, wantRob},
		'{1, 0, 1, 3'd2, 0, 2'd3, 0, 3'd0, wantRob},
		'{1, 0, 1, 3'd3, 1, 2'd1, 0, 3'd2, wantRob},
		'{1, 0, 1, 3'd4, 1, 2'd0, 0, 3'd5, wantRob},
		'{1, 0, 1, 3'd5, 0, 2'd2, 0, 3'd4, wantRob},
		'{1, 0, 1, 3'd6, 1, 2'd3, 0, 3'd0, wantRob},
		'{1, 0, 1, 3'd7, 1, 2'd2, 0, 3'd0, wantRob},
		'{0, 1, 1, 3'd7, 1, 2'd2, 0, 3'd0, wantBeb},
		'{0, 1, 1, 3'd5, 0, 2'd3, 0, 3'd6, wantBeb},
		'{1, 1, 1, 3'd2, 1, 2'd1, 0, 3'd2, wantRob},
		'{1, 1, 1, 3'd0, 0, 2'd0, 1, 3'd3, wantRob},
		'{1, 0, 0, 3'd1, 1, 2'd2, 0, 3'd0, wantDrop},
		'{0, 1, 0, 3'd0, 0, 2'd1, 0, 3'd0, wantDrop},
		'{1, 1, 0, 3'd0, 1, 2'd3, 1, 3'd0, wantDrop},
		'{0, 0, 1, 3'd0, 0, 2'd0, 0, 3'd0, wantDrop},
		'{1, 0, 1, 3'd3, 0, 2'd1, 0, 3'd1, wantRob},
		'{0, 1, 1, 3'd0, 1, 2'd2, 0, 3'd2, wantBeb},
		'{1, 0, 1, 3'd0, 1, 2'd3, 1, 3'd4, wantRob},
		'{0, 1, 1, 3'd0, 0, 2'd2, 1, 3'd0, wantBeb},
		'{0, 1, 1, 3'd0, 0, 2'd0, 0, 3'd7, wantBeb}
	};

	logic clk = 1'b0;
	logic rst, idle_i, robIssue_i, robNegA_i, robNegB_i, robNegC_i, robStore_i, robExc_i;
	logic bebIssue_i, bebStore_i, bebExc_i;
	logic idle_o, reqValid_o, reqStore_o, reqExc_o;
	robId_t robId_i, bebId_i, reqId_o;
	value_t robArgA_i, robArgB_i, robArgC_i, bebArgA_i, bebArgB_i, bebArgC_i, reqData_o;
	address_t robImm_i, bebImm_i, reqAddr_o;
	accSize_t robSize_i, bebSize_i, reqSize_o;

	integer seed = 32'h998e29c5;
	int cyc = 0;
	int errs = 0;
	int checks = 0;
	logic idleSeen = 1'b0;
	expReq_t expQ [$];
	expReq_t got;

	agen_top dut_i (.*);

	always #10 clk = ~clk;

	// ================================================
	// Cycle count and run limit
	// ================================================
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == cycleLimit) begin
			$display("Run stopped at cycle %0d with %0d requests never seen", cyc, expQ.size());
			$display("checks %0d, errors %0d", checks, errs);
			$display("sim failed");
			$finish;
		end
	end

	task automatic checkField(input string name, input logic [31:0] val, input logic [31:0] exp);
		checks++;
		assert (val === exp) else begin
			errs++;
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, val, exp);
		end
	endtask

	// Drives one row and predicts its request from the selection, negation and address rules
	task automatic driveRow(input tableRow_t r);
		value_t ra, rb, rc, ba, bb, bc, na, nb, nc;
		address_t ri, bi;
		robId_t rid;
		expReq_t e;
		logic [1:0] src;
		ra = $random(seed);
		rb = $random(seed);
		rc = $random(seed);
		ri = $random(seed);
		ba = $random(seed);
		bb = $random(seed);
		bc = $random(seed);
		bi = $random(seed);
		rid = $random(seed);
		// Only ROB operands are negated
		na = r.neg[0] ? -ra : ra;
		nb = r.neg[1] ? -rb : rb;
		nc = r.neg[2] ? -rc : rc;
		// Bend each immediate so the sum ends in the row's low bits
		ri = ri - ((na + nb + ri) & 32'd7) + r.low;
		bi = bi - ((ba + bb + bi) & 32'd7) + r.low;
		{robIssue_i, bebIssue_i, idle_i} <= {r.rob, r.beb, r.idle};
		{robNegC_i, robNegB_i, robNegA_i} <= r.neg;
		{robStore_i, robSize_i, robExc_i} <= {r.st, r.sz, r.exc};
		{bebStore_i, bebSize_i, bebExc_i} <= {r.st, r.sz, r.exc};
		{robId_i, bebId_i} <= {rid, rid + robId_t'(1)};
		{robArgA_i, robArgB_i, robArgC_i, robImm_i} <= {ra, rb, rc, ri};
		{bebArgA_i, bebArgB_i, bebArgC_i, bebImm_i} <= {ba, bb, bc, bi};
		src = wantDrop;
		if (r.idle && r.rob) begin
			src = wantRob;
			e.id = rid;
			e.addr = na + nb + ri;
			e.data = r.st ? nc : value_t'(0);
		end else if (r.idle && r.beb) begin
			src = wantBeb;
			e.id = rid + robId_t'(1);
			e.addr = ba + bb + bi;
			e.data = r.st ? bc : value_t'(0);
		end
		assert (src == r.want) else begin
			errs++;
			$display("Table row expects source %0d but the selection rules give %0d", r.want, src);
		end
		if (src != wantDrop) begin
			e.st = r.st;
			e.sz = r.sz;
			e.exc = r.exc | ((e.addr & ((address_t'(1) << r.sz) - 1)) != 0);
			// The count still lags this edge by one, and the request shows three edges later
			e.due = cyc + 4;
			expQ.push_back(e);
		end
	endtask

	// ================================================
	// Response checks on the falling edge
	// ================================================
	always @(negedge clk) begin
		if (!rst) begin
			checkField("idle_o", idle_o, idleSeen);
			idleSeen = idle_i;
			if (!reqValid_o) begin
				checkField("reqExc_o", reqExc_o, 0);
			end else if (expQ.size() == 0) begin
				errs++;
				$display("Request with id %0h appeared when none was expected", reqId_o);
			end else begin
				got = expQ.pop_front();
				assert (cyc == got.due) else begin
					errs++;
					$display("Request for id %0h came at cycle %0d, not %0d", got.id, cyc, got.due);
				end
				checkField("reqId_o", reqId_o, got.id);
				checkField("reqAddr_o", reqAddr_o, got.addr);
				checkField("reqStore_o", reqStore_o, got.st);
				checkField("reqSize_o", reqSize_o, got.sz);
				checkField("reqData_o", reqData_o, got.data);
				checkField("reqExc_o", reqExc_o, got.exc);
			end
		end
	end

	initial begin
		rst <= 1'b1;
		driveRow('0);
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// Back-to-back rows, one per cycle
		for (int i = 0; i < nRows; i++) begin
			@(posedge clk);
			driveRow(rows[i]);
		end
		@(posedge clk);
		driveRow('0);
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("checks %0d, errors %0d, requests left %0d", checks, errs, expQ.size());
		if (errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+include
rtl/agen_pkg.sv
rtl/agen_if.sv
rtl/agen_issue_select.sv
rtl/agen_station.sv
rtl/agen_addr_calc.sv
rtl/agen_top.sv
bench/agen_tb.sv

/* include/agen_consts.svh */
// ================================================
// Widths and access-size codes for the address generator
// Included by the package and by any block that decodes sizes
// ================================================
`ifndef AGEN_CONSTS_SVH
`define AGEN_CONSTS_SVH

// Effective and base addresses
`define AGEN_ADDR_W 32

// Register operands and store data
`define AGEN_VALUE_W 32

// Reorder buffer index, enough for 32 entries
`define AGEN_ROBID_W 5

// Access size is log2 of the byte count
`define AGEN_SIZE_W 2
`define AGEN_SIZE_BYTE 2'd0
`define AGEN_SIZE_HALF 2'd1
`define AGEN_SIZE_WORD 2'd2
`define AGEN_SIZE_DOUBLE 2'd3

`endif

/* rtl/agen_addr_calc.sv */
// ================================================
// Output stage that forms the effective address
// Flags misaligned accesses and registers the memory request
// ================================================
`timescale 1ns/1ps
`include "agen_consts.svh"

module agen_addr_calc import agen_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	stationBus.dst   stage,
	output logic     reqValid_o,
	output robId_t   reqId_o,
	output address_t reqAddr_o,
	output logic     reqStore_o,
	output accSize_t reqSize_o,
	output value_t   reqData_o,
	output logic     reqExc_o
);

	// Sum of the three terms, wrapping at the address width
	address_t effAddr;
	logic     misAligned;

	assign effAddr = address_t'(stage.argA) + address_t'(stage.argB) + stage.imm;

	// Each size needs that many low address bits to be zero
	always_comb begin
		case (stage.size)
			`AGEN_SIZE_BYTE:   misAligned = 1'b0;
			`AGEN_SIZE_HALF:   misAligned = effAddr[0];
			`AGEN_SIZE_WORD:   misAligned = |effAddr[1:0];
			`AGEN_SIZE_DOUBLE: misAligned = |effAddr[2:0];
			default:           misAligned = 1'b0;
		endcase
	end

	// Strobe and fault flag are only high for a live entry
	always_ff @(posedge clk) begin
		if (rst) begin
			reqValid_o <= 1'b0;
			reqExc_o   <= 1'b0;
		end else begin
			reqValid_o <= stage.valid;
			reqExc_o   <= stage.valid & (stage.exc | misAligned);
		end
	end

	// Request payload, loads present zero on the data lines
	always_ff @(posedge clk) begin
		if (stage.valid) begin
			reqId_o    <= stage.id;
			reqAddr_o  <= effAddr;
			reqStore_o <= stage.isStore;
			reqSize_o  <= stage.size;
			reqData_o  <= stage.isStore ? stage.argC : value_t'(0);
		end
	end

endmodule

/* rtl/agen_if.sv */
// ================================================
// Buses between the three address-generation stages
// One carries the chosen issue entry, one the latched entry
// ================================================
`timescale 1ns/1ps

// Entry picked by the issue selector, before negation
// Valid is a one-cycle strobe per accepted entry
interface issueBus import agen_pkg::*; ();
	logic     valid;
	logic     fromRob;
	robId_t   id;
	value_t   argA;
	value_t   argB;
	value_t   argC;
	address_t imm;
	logic     negA;
	logic     negB;
	logic     negC;
	logic     isStore;
	accSize_t size;
	logic     exc;

	// The selector drives every field
	modport src (
		output valid, fromRob, id, argA, argB, argC, imm,
		output negA, negB, negC, isStore, size, exc
	);

	// The station samples every field
	modport dst (
		input valid, fromRob, id, argA, argB, argC, imm,
		input negA, negB, negC, isStore, size, exc
	);
endinterface

// Entry held by the station with operands already negated
// Negate flags and the source bit are consumed by then
interface stationBus import agen_pkg::*; ();
	logic     valid;
	robId_t   id;
	value_t   argA;
	value_t   argB;
	value_t   argC;
	address_t imm;
	logic     isStore;
	accSize_t size;
	logic     exc;

	modport src (output valid, id, argA, argB, argC, imm, isStore, size, exc);

	modport dst (input valid, id, argA, argB, argC, imm, isStore, size, exc);
endinterface

/* rtl/agen_issue_select.sv */
// ================================================
// Input stage that picks a ROB or BEB entry each cycle
// Nothing is taken while idle is low, and ROB wins a tie
// ================================================
`timescale 1ns/1ps

module agen_issue_select import agen_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     idle_i,
	input  logic     robIssue_i,
	input  robId_t   robId_i,
	input  value_t   robArgA_i,
	input  value_t   robArgB_i,
	input  value_t   robArgC_i,
	input  address_t robImm_i,
	input  logic     robNegA_i,
	input  logic     robNegB_i,
	input  logic     robNegC_i,
	input  logic     robStore_i,
	input  accSize_t robSize_i,
	input  logic     robExc_i,
	input  logic     bebIssue_i,
	input  robId_t   bebId_i,
	input  value_t   bebArgA_i,
	input  value_t   bebArgB_i,
	input  value_t   bebArgC_i,
	input  address_t bebImm_i,
	input  logic     bebStore_i,
	input  accSize_t bebSize_i,
	input  logic     bebExc_i,
	issueBus.src     issue
);

	// The idle level gates both sources the same way
	logic robTake;
	logic bebTake;

	assign robTake = robIssue_i & idle_i;
	// A BEB request only counts when the ROB is silent
	assign bebTake = bebIssue_i & idle_i & ~robIssue_i;

	// One strobe per accepted entry, whichever source it came from
	always_ff @(posedge clk) begin
		if (rst) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= robTake | bebTake;
		end
	end

	// Payload of the winner, held when nothing is accepted
	always_ff @(posedge clk) begin
		if (robTake) begin
			issue.fromRob <= 1'b1;
			issue.id      <= robId_i;
			issue.argA    <= robArgA_i;
			issue.argB    <= robArgB_i;
			issue.argC    <= robArgC_i;
			issue.imm     <= robImm_i;
			issue.negA    <= robNegA_i;
			issue.negB    <= robNegB_i;
			issue.negC    <= robNegC_i;
			issue.isStore <= robStore_i;
			issue.size    <= robSize_i;
			issue.exc     <= robExc_i;
		end else if (bebTake) begin
			// Replayed operands are already prepared, so no negation
			issue.fromRob <= 1'b0;
			issue.id      <= bebId_i;
			issue.argA    <= bebArgA_i;
			issue.argB    <= bebArgB_i;
			issue.argC    <= bebArgC_i;
			issue.imm     <= bebImm_i;
			issue.negA    <= 1'b0;
			issue.negB    <= 1'b0;
			issue.negC    <= 1'b0;
			issue.isStore <= bebStore_i;
			issue.size    <= bebSize_i;
			issue.exc     <= bebExc_i;
		end
	end

endmodule

/* rtl/agen_pkg.sv */
// ================================================
// Shared types of the address-generation pipeline
// Imported by every stage, the top level and the testbench
// ================================================

package agen_pkg;

	`include "agen_consts.svh"

	// ================================================
	// Address path
	// ================================================

	// An effective address or one of its base terms
	// The immediate is carried at this width as well
	typedef logic [`AGEN_ADDR_W-1:0] address_t;

	// ================================================
	// Operand path
	// ================================================

	// A register operand as read from the register file
	// Also used for the store datum on the request side
	typedef logic [`AGEN_VALUE_W-1:0] value_t;

	// ================================================
	// Control fields
	// ================================================

	// Tag that names the instruction in the reorder buffer
	// It travels unchanged from issue to the memory request
	typedef logic [`AGEN_ROBID_W-1:0] robId_t;

	// Access size code, 0 for bytes up to 3 for double words
	// The code also gives how many low address bits must be zero
	typedef logic [`AGEN_SIZE_W-1:0] accSize_t;

endpackage

/* rtl/agen_station.sv */
// ================================================
// Station stage that latches the issued entry
// Applies the ROB negate flags and echoes the idle level
// ================================================
`timescale 1ns/1ps

module agen_station import agen_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  idle_i,
	output logic  idle_o,
	issueBus.dst  issue,
	stationBus.src stage
);

	// ================================================
	// Operand negation
	// ================================================

	// Two's-complement negation when the flag is set
	function automatic value_t condNeg(input value_t v, input logic flip);
		value_t r;
		if (flip) begin
			r = ~v + value_t'(1);
		end else begin
			r = v;
		end
		return r;
	endfunction

	// Flags only count for entries that came from the ROB
	logic flipA;
	logic flipB;
	logic flipC;

	assign flipA = issue.fromRob & issue.negA;
	assign flipB = issue.fromRob & issue.negB;
	assign flipC = issue.fromRob & issue.negC;

	// Operands after the negate step, ready to latch
	value_t nextA;
	value_t nextB;
	value_t nextC;

	assign nextA = condNeg(issue.argA, flipA);
	assign nextB = condNeg(issue.argB, flipB);
	assign nextC = condNeg(issue.argC, flipC);

	// ================================================
	// Pipeline register
	// ================================================

	// Valid follows the issue strobe one cycle later
	// Idle is echoed on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			stage.valid <= 1'b0;
			idle_o      <= 1'b0;
		end else begin
			stage.valid <= issue.valid;
			idle_o      <= idle_i;
		end
	end

	// Fields hold their last entry until a new one arrives
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			stage.id      <= issue.id;
			stage.argA    <= nextA;
			stage.argB    <= nextB;
			stage.argC    <= nextC;
			stage.imm     <= issue.imm;
			stage.isStore <= issue.isStore;
			stage.size    <= issue.size;
			stage.exc     <= issue.exc;
		end
	end

endmodule

/* rtl/agen_top.sv */
// ================================================
// Address generator top with the three stages in a row
// An accepted entry leaves as a request three cycles later
// ================================================
`timescale 1ns/1ps

module agen_top import agen_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     idle_i,
	input  logic     robIssue_i,
	input  robId_t   robId_i,
	input  value_t   robArgA_i,
	input  value_t   robArgB_i,
	input  value_t   robArgC_i,
	input  address_t robImm_i,
	input  logic     robNegA_i,
	input  logic     robNegB_i,
	input  logic     robNegC_i,
	input  logic     robStore_i,
	input  accSize_t robSize_i,
	input  logic     robExc_i,
	input  logic     bebIssue_i,
	input  robId_t   bebId_i,
	input  value_t   bebArgA_i,
	input  value_t   bebArgB_i,
	input  value_t   bebArgC_i,
	input  address_t bebImm_i,
	input  logic     bebStore_i,
	input  accSize_t bebSize_i,
	input  logic     bebExc_i,
	output logic     idle_o,
	output logic     reqValid_o,
	output robId_t   reqId_o,
	output address_t reqAddr_o,
	output logic     reqStore_o,
	output accSize_t reqSize_o,
	output value_t   reqData_o,
	output logic     reqExc_o
);

	// Selector to station, then station to address calculator
	issueBus   issueLink ();
	stationBus stageLink ();

	agen_issue_select issueSelect (
		.clk, .rst, .idle_i,
		.robIssue_i, .robId_i, .robArgA_i, .robArgB_i, .robArgC_i, .robImm_i,
		.robNegA_i, .robNegB_i, .robNegC_i, .robStore_i, .robSize_i, .robExc_i,
		.bebIssue_i, .bebId_i, .bebArgA_i, .bebArgB_i, .bebArgC_i, .bebImm_i,
		.bebStore_i, .bebSize_i, .bebExc_i,
		.issue (issueLink)
	);

	// The station also produces the delayed idle level
	agen_station station (
		.clk, .rst, .idle_i, .idle_o,
		.issue (issueLink),
		.stage (stageLink)
	);

	agen_addr_calc addrCalc (
		.clk, .rst,
		.stage (stageLink),
		.reqValid_o, .reqId_o, .reqAddr_o, .reqStore_o,
		.reqSize_o, .reqData_o, .reqExc_o
	);

endmodule
